// ==== decoder_defines.svh ====
`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// size of the decoder line
`define DECODER_N_VERTICES 8   // also the number of links
`define DECODER_ADDR_WIDTH 3

// link weights
`define DECODER_MAX_WEIGHT 3
`define DECODER_WEIGHT_WIDTH $clog2(`DECODER_MAX_WEIGHT + 1)

// grow phase length, in cycles
`define DECODER_GROW_WIDTH 4

`endif

// ==== decoder_pkg.sv ====
`include "decoder_defines.svh"

package decoder_pkg;

    // global stage, driven by the controller to every vertex and link
    typedef enum logic [2:0] {
        STAGE_IDLE    = 3'd0,
        STAGE_PARAMS  = 3'd1,
        STAGE_MEASURE = 3'd2,
        STAGE_GROW    = 3'd3,
        STAGE_MERGE   = 3'd4
    } stage_t;

    typedef enum logic [1:0] {
        LINK_NORMAL   = 2'd0,  // joins two vertices
        LINK_BOUNDARY = 2'd1,  // only the a side is live
        LINK_ABSENT   = 2'd2   // never grows
    } link_kind_t;

    // per-link configuration, loaded in STAGE_PARAMS
    typedef struct packed {
        logic [`DECODER_WEIGHT_WIDTH-1:0] weight;
        link_kind_t                       kind;
    } link_cfg_t;

    // what a vertex shows its links during merging
    typedef struct packed {
        logic [`DECODER_ADDR_WIDTH-1:0] root;      // smallest address seen so far
        logic                           boundary;  // cluster reaches the boundary
    } vertex_data_t;

endpackage

// ==== stage_controller.sv ====
`include "decoder_defines.svh"

module stage_controller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_params,
    input  logic                           start,
    input  logic [`DECODER_GROW_WIDTH-1:0] grow_cycles,
    output decoder_pkg::stage_t            stage,
    output logic                           busy,
    output logic                           done
);

    localparam int merge_width = $clog2(`DECODER_N_VERTICES + 1);
    localparam int cnt_width   = (`DECODER_GROW_WIDTH > merge_width) ?
                                 `DECODER_GROW_WIDTH : merge_width;

    logic [`DECODER_GROW_WIDTH-1:0] grow_q;  // grow count for this round
    logic [cnt_width-1:0]           cnt;     // cycles left in grow or merge

    // grow count is taken with the start pulse
    always_ff @(posedge clk) begin
        if (start && stage == decoder_pkg::STAGE_IDLE) begin
            grow_q <= grow_cycles;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= decoder_pkg::STAGE_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (stage)
                decoder_pkg::STAGE_IDLE: begin
                    if (load_params) begin  // parameter load wins a tie
                        stage <= decoder_pkg::STAGE_PARAMS;
                    end else if (start) begin
                        stage <= decoder_pkg::STAGE_MEASURE;
                    end
                end
                decoder_pkg::STAGE_PARAMS: begin
                    stage <= decoder_pkg::STAGE_IDLE;  // one cycle is enough
                end
                decoder_pkg::STAGE_MEASURE: begin
                    if (grow_q == '0) begin
                        stage <= decoder_pkg::STAGE_MERGE;
                        cnt   <= cnt_width'(`DECODER_N_VERTICES);
                    end else begin
                        stage <= decoder_pkg::STAGE_GROW;
                        cnt   <= cnt_width'(grow_q);
                    end
                end
                decoder_pkg::STAGE_GROW: begin
                    if (cnt == cnt_width'(1)) begin
                        stage <= decoder_pkg::STAGE_MERGE;
                        cnt   <= cnt_width'(`DECODER_N_VERTICES);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                decoder_pkg::STAGE_MERGE: begin
                    // one merge step per vertex covers the whole line
                    if (cnt == cnt_width'(1)) begin
                        stage <= decoder_pkg::STAGE_IDLE;
                        done  <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    stage <= decoder_pkg::STAGE_IDLE;
                end
            endcase
        end
    end

    assign busy = stage != decoder_pkg::STAGE_IDLE;

endmodule

// ==== link_unit.sv ====
`include "decoder_defines.svh"

module link_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  decoder_pkg::stage_t       stage,
    input  decoder_pkg::link_cfg_t    cfg_in,
    input  logic                      a_increase,
    input  logic                      b_increase,
    input  decoder_pkg::vertex_data_t a_data_in,
    input  decoder_pkg::vertex_data_t b_data_in,
    output logic                      a_valid_out,
    output logic                      b_valid_out,
    output decoder_pkg::vertex_data_t a_data_out,
    output decoder_pkg::vertex_data_t b_data_out,
    output logic                      boundary_hit,
    output logic                      fully_grown
);

    logic [`DECODER_WEIGHT_WIDTH-1:0] weight;
    decoder_pkg::link_kind_t          kind;
    logic [`DECODER_WEIGHT_WIDTH-1:0] growth;
    logic [`DECODER_WEIGHT_WIDTH:0]   growth_sum;  // one extra bit before saturation
    logic                             is_grown;
    logic                             passes;

    // growth from the live sides only
    always_comb begin
        case (kind)
            decoder_pkg::LINK_NORMAL:   growth_sum = {1'b0, growth} + a_increase + b_increase;
            decoder_pkg::LINK_BOUNDARY: growth_sum = {1'b0, growth} + a_increase;
            default:                    growth_sum = {1'b0, growth};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            weight      <= '0;
            kind        <= decoder_pkg::LINK_ABSENT;  // unconfigured link stays out
            growth      <= '0;
            fully_grown <= 1'b0;
        end else begin
            case (stage)
                decoder_pkg::STAGE_PARAMS: begin
                    weight <= cfg_in.weight;
                    kind   <= cfg_in.kind;
                end
                decoder_pkg::STAGE_MEASURE: begin
                    growth <= '0;
                end
                decoder_pkg::STAGE_GROW: begin
                    growth <= (growth_sum > weight) ? weight : growth_sum[`DECODER_WEIGHT_WIDTH-1:0];
                end
                decoder_pkg::STAGE_MERGE: begin
                    fully_grown <= is_grown;  // held for the outside until the next merge
                end
                default: begin
                end
            endcase
        end
    end

    // zero weight means grown right away
    assign is_grown = (kind != decoder_pkg::LINK_ABSENT) && (growth >= weight);
    assign passes   = is_grown && (kind == decoder_pkg::LINK_NORMAL);

    // each side sees the other side's data
    assign a_valid_out  = passes;
    assign b_valid_out  = passes;
    assign a_data_out   = passes ? b_data_in : '0;
    assign b_data_out   = passes ? a_data_in : '0;
    assign boundary_hit = is_grown && (kind == decoder_pkg::LINK_BOUNDARY);

endmodule

// ==== vertex_unit.sv ====
`include "decoder_defines.svh"

module vertex_unit #(
    parameter logic [`DECODER_ADDR_WIDTH-1:0] vertex_addr = '0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  decoder_pkg::stage_t       stage,
    input  logic                      defect_in,
    output logic                      increase,
    input  logic                      left_valid,
    input  logic                      right_valid,
    input  decoder_pkg::vertex_data_t left_data,
    input  decoder_pkg::vertex_data_t right_data,
    input  logic                      boundary_hit,
    output decoder_pkg::vertex_data_t data
);

    logic                      defect;  // measured defect of this round
    decoder_pkg::vertex_data_t merged;

    // smallest root among self and valid neighbours
    always_comb begin
        merged = data;
        if (left_valid && left_data.root < merged.root) begin
            merged.root = left_data.root;
        end
        if (right_valid && right_data.root < merged.root) begin
            merged.root = right_data.root;
        end
        merged.boundary = data.boundary | boundary_hit |
                          (left_valid & left_data.boundary) |
                          (right_valid & right_data.boundary);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect <= 1'b0;
            data   <= '0;
        end else begin
            case (stage)
                decoder_pkg::STAGE_MEASURE: begin
                    defect        <= defect_in;
                    data.root     <= vertex_addr;  // every vertex starts as its own root
                    data.boundary <= 1'b0;
                end
                decoder_pkg::STAGE_MERGE: begin
                    data <= merged;  // spreads one hop per cycle
                end
                default: begin
                end
            endcase
        end
    end

    // a defect pushes growth into both neighbouring links
    assign increase = defect && (stage == decoder_pkg::STAGE_GROW);

endmodule

// ==== decoder_chain.sv ====
`include "decoder_defines.svh"

module decoder_chain (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_params,
    input  decoder_pkg::link_cfg_t         link_cfg [`DECODER_N_VERTICES],
    input  logic                           start,
    input  logic [`DECODER_N_VERTICES-1:0] defects,
    input  logic [`DECODER_GROW_WIDTH-1:0] grow_cycles,
    output logic                           busy,
    output logic                           done,
    output decoder_pkg::vertex_data_t      roots [`DECODER_N_VERTICES],
    output logic [`DECODER_N_VERTICES-1:0] grown
);

    decoder_pkg::stage_t            stage;
    logic                           idle;
    decoder_pkg::link_cfg_t         cfg_q [`DECODER_N_VERTICES];
    logic [`DECODER_N_VERTICES-1:0] defects_q;

    // vertex side
    logic [`DECODER_N_VERTICES-1:0] v_increase;
    decoder_pkg::vertex_data_t      v_data [`DECODER_N_VERTICES];
    logic [`DECODER_N_VERTICES-1:0] left_valid;
    decoder_pkg::vertex_data_t      left_data [`DECODER_N_VERTICES];

    // link i sits between vertex i (a) and vertex i+1 (b)
    logic [`DECODER_N_VERTICES-1:0] a_valid;
    decoder_pkg::vertex_data_t      a_data_out [`DECODER_N_VERTICES];
    logic [`DECODER_N_VERTICES-1:0] b_valid;
    decoder_pkg::vertex_data_t      b_data_out [`DECODER_N_VERTICES];
    logic [`DECODER_N_VERTICES-1:0] b_increase;
    decoder_pkg::vertex_data_t      b_data_in [`DECODER_N_VERTICES];
    logic [`DECODER_N_VERTICES-1:0] boundary_hit;

    assign idle = stage == decoder_pkg::STAGE_IDLE;

    // inputs sampled on the accepted pulse
    always_ff @(posedge clk) begin
        if (load_params && idle) begin
            cfg_q <= link_cfg;
        end
        if (start && idle) begin
            defects_q <= defects;
        end
    end

    stage_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .load_params (load_params),
        .start       (start),
        .grow_cycles (grow_cycles),
        .stage       (stage),
        .busy        (busy),
        .done        (done)
    );

    for (genvar i = 0; i < `DECODER_N_VERTICES; i++) begin : g_line
        if (i == 0) begin : g_first
            assign left_valid[i] = 1'b0;
            assign left_data[i]  = '0;
        end else begin : g_left
            assign left_valid[i] = b_valid[i-1];
            assign left_data[i]  = b_data_out[i-1];
        end

        if (i == `DECODER_N_VERTICES - 1) begin : g_last
            assign b_increase[i] = 1'b0;  // last link has no b side
            assign b_data_in[i]  = '0;
        end else begin : g_right
            assign b_increase[i] = v_increase[i+1];
            assign b_data_in[i]  = v_data[i+1];
        end

        vertex_unit #(
            .vertex_addr (i)
        ) u_vertex (
            .clk          (clk),
            .reset        (reset),
            .stage        (stage),
            .defect_in    (defects_q[i]),
            .increase     (v_increase[i]),
            .left_valid   (left_valid[i]),
            .right_valid  (a_valid[i]),
            .left_data    (left_data[i]),
            .right_data   (a_data_out[i]),
            .boundary_hit (boundary_hit[i]),
            .data         (v_data[i])
        );

        link_unit u_link (
            .clk          (clk),
            .reset        (reset),
            .stage        (stage),
            .cfg_in       (cfg_q[i]),
            .a_increase   (v_increase[i]),
            .b_increase   (b_increase[i]),
            .a_data_in    (v_data[i]),
            .b_data_in    (b_data_in[i]),
            .a_valid_out  (a_valid[i]),
            .b_valid_out  (b_valid[i]),
            .a_data_out   (a_data_out[i]),
            .b_data_out   (b_data_out[i]),
            .boundary_hit (boundary_hit[i]),
            .fully_grown  (grown[i])
        );

        assign roots[i] = v_data[i];
    end

endmodule

// ==== tb_decoder_chain.sv ====
`include "decoder_defines.svh"

module tb_decoder_chain;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n            = `DECODER_N_VERTICES;
    localparam int n_rounds     = 40;
    localparam int round_cycles = 40;  // params load plus longest grow and merge
    localparam int timeout_ns   = (16 + (n_rounds + 2) * round_cycles) * 8;

    logic                           clk;
    logic                           reset;
    logic                           load_params;
    logic                           start;
    decoder_pkg::link_cfg_t         link_cfg [n];
    logic [n-1:0]                   defects;
    logic [`DECODER_GROW_WIDTH-1:0] grow_cycles;
    logic                           busy;
    logic                           done;
    decoder_pkg::vertex_data_t      roots [n];
    logic [n-1:0]                   grown;

    integer seed = 20;
    int     errors = 0;

    // reference model
    logic [`DECODER_WEIGHT_WIDTH-1:0] model_weight [n];
    decoder_pkg::link_kind_t          model_kind [n];
    logic                             exp_grown [n];
    int                               exp_root [n];
    logic                             exp_bnd [n];

    decoder_chain i_dut (
        .clk         (clk),
        .reset       (reset),
        .load_params (load_params),
        .link_cfg    (link_cfg),
        .start       (start),
        .defects     (defects),
        .grow_cycles (grow_cycles),
        .busy        (busy),
        .done        (done),
        .roots       (roots),
        .grown       (grown)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: run went past %0d ns, the DUT stopped finishing rounds", timeout_ns);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    // growth saturates at the weight and components are runs of grown normal links
    task automatic compute_model(input logic [n-1:0] dfx, input int gc);
        int   sum;
        int   g;
        logic hit [n];
        logic bnd_of_root [n];
        for (int i = 0; i < n; i++) begin
            sum = dfx[i];
            if (i < n - 1 && model_kind[i] == decoder_pkg::LINK_NORMAL) begin
                sum += dfx[i+1];
            end
            g = gc * sum;
            if (g > model_weight[i]) begin
                g = model_weight[i];
            end
            exp_grown[i]   = model_kind[i] != decoder_pkg::LINK_ABSENT && g >= model_weight[i];
            hit[i]         = exp_grown[i] && model_kind[i] == decoder_pkg::LINK_BOUNDARY;
            bnd_of_root[i] = 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            if (i > 0 && exp_grown[i-1] && model_kind[i-1] == decoder_pkg::LINK_NORMAL) begin
                exp_root[i] = exp_root[i-1];
            end else begin
                exp_root[i] = i;
            end
        end
        for (int i = 0; i < n; i++) begin
            if (hit[i]) bnd_of_root[exp_root[i]] = 1'b1;
        end
        for (int i = 0; i < n; i++) begin
            exp_bnd[i] = bnd_of_root[exp_root[i]];
        end
    endtask

    task automatic check_results();
        for (int i = 0; i < n; i++) begin
            check_value(roots[i].root, exp_root[i], $sformatf("root of vertex %0d", i));
            check_value(roots[i].boundary, exp_bnd[i], $sformatf("boundary of vertex %0d", i));
            check_value(grown[i], exp_grown[i], $sformatf("grown bit of link %0d", i));
        end
    endtask

    task automatic load_config();
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            model_weight[i] = rnd[`DECODER_WEIGHT_WIDTH-1:0];
            if (i < n - 1) begin
                model_kind[i] = decoder_pkg::link_kind_t'(rnd[15:8] % 3);
            end else begin
                // last link has no b side
                model_kind[i] = rnd[8] ? decoder_pkg::LINK_BOUNDARY : decoder_pkg::LINK_ABSENT;
            end
            link_cfg[i].weight = model_weight[i];
            link_cfg[i].kind   = model_kind[i];
        end
        load_params = 1'b1;
        @(negedge clk);
        load_params = 1'b0;
        check_value(busy, 1'b1, "busy during parameter stage");
        @(negedge clk);
        check_value(busy, 1'b0, "busy after parameter stage");
    endtask

    task automatic run_round(input logic [n-1:0] dfx,
                             input logic [`DECODER_GROW_WIDTH-1:0] gc, input bit junk);
        int          cyc;
        int          junk_at;
        logic [31:0] rnd;
        compute_model(dfx, gc);
        rnd         = $random(seed);
        junk_at     = rnd[3:0];
        defects     = dfx;
        grow_cycles = gc;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value(busy, 1'b1, "busy after start");
        cyc = 0;
        while (done !== 1'b1) begin
            if (junk && cyc == junk_at && busy) begin
                rnd                = $random(seed);  // must be ignored while busy
                defects            = rnd[n-1:0];
                grow_cycles        = rnd[11:8];
                link_cfg[0].weight = ~link_cfg[0].weight;
                load_params        = 1'b1;
                start              = 1'b1;
            end
            @(negedge clk);
            load_params = 1'b0;
            start       = 1'b0;
            cyc++;
            if (cyc > round_cycles) begin
                $display("timeout: done did not arrive within %0d cycles of start", round_cycles);
                $display("Something failed");
                $fatal(1, "round timeout");
            end
        end
        // measure, grow, one merge cycle per vertex
        check_value(cyc, 1 + gc + n, "cycles from start to done");
        check_value(busy, 1'b0, "busy on the done cycle");
        check_results();
        @(negedge clk);
        check_value(done, 1'b0, "done lasts one cycle");
    endtask

    initial begin
        logic [31:0]                    rnd;
        logic [`DECODER_GROW_WIDTH-1:0] gc;
        reset       = 1'b1;
        load_params = 1'b0;
        start       = 1'b0;
        defects     = '0;
        grow_cycles = '0;
        for (int i = 0; i < n; i++) begin
            link_cfg[i] = '0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;

        check_value(busy, 1'b0, "busy after reset");
        check_value(done, 1'b0, "done after reset");
        for (int i = 0; i < n; i++) begin
            check_value(roots[i], 0, $sformatf("roots[%0d] after reset", i));
            check_value(grown[i], 0, $sformatf("grown[%0d] after reset", i));
        end

        // nothing loaded yet, so every link is absent
        for (int i = 0; i < n; i++) begin
            model_weight[i] = '0;
            model_kind[i]   = decoder_pkg::LINK_ABSENT;
        end
        rnd = $random(seed);
        run_round(rnd[n-1:0], 3, 1'b0);

        for (int r = 0; r < n_rounds; r++) begin
            if (r % 5 == 0) load_config();
            rnd = $random(seed);
            if (r % 7 == 3) begin
                gc = '0;  // only zero-weight links grow
            end else if (r % 2 == 1) begin
                gc = rnd[9:8];
            end else begin
                gc = rnd[11:8];
            end
            run_round(rnd[n-1:0], gc, r % 3 == 1);
        end

        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
decoder_pkg.sv
stage_controller.sv
link_unit.sv
vertex_unit.sv
decoder_chain.sv
tb_decoder_chain.sv

// ==== Bender.yml ====
package:
  name: decoder_chain

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - decoder_pkg.sv
      - stage_controller.sv
      - link_unit.sv
      - vertex_unit.sv
      - decoder_chain.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decoder_chain.sv
